//--- hw/alu_health_pkg.sv
// Address map and operator codes are fixed; NUM_LANES must stay a power of two for CSR decoding
package alu_health_pkg;

  ////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////
  localparam int unsigned NUM_LANES   = 4;
  localparam int unsigned NUM_CLASSES = 9;
  localparam int unsigned CNT_W       = 32;

  // Operator codes as issued by the core, subset only
  typedef enum logic [6:0] {
    ALU_LTS  = 7'b0000000,
    ALU_EQ   = 7'b0001100,
    ALU_MIN  = 7'b0010000,
    ALU_MAX  = 7'b0010010,
    ALU_ABS  = 7'b0010100,
    ALU_AND  = 7'b0010101,
    ALU_CLIP = 7'b0010110,
    ALU_ADD  = 7'b0011000,
    ALU_SUB  = 7'b0011001,
    ALU_SRA  = 7'b0100100,
    ALU_SRL  = 7'b0100101,
    ALU_SLL  = 7'b0100111,
    ALU_BEXT = 7'b0101000,
    ALU_BCLR = 7'b0101011,
    ALU_BSET = 7'b0101100,
    ALU_OR   = 7'b0101110,
    ALU_XOR  = 7'b0101111,
    ALU_DIV  = 7'b0110001,
    ALU_REM  = 7'b0110011,
    ALU_CNT  = 7'b0110100,
    ALU_FF1  = 7'b0110110,
    ALU_SHUF = 7'b0111010,
    ALU_EXT  = 7'b0111111
  } alu_op_t;

  // Fault classes, one counter each per lane
  typedef enum logic [3:0] {
    CLASS_SHIFT_ADD = 4'd0,
    CLASS_LOGIC     = 4'd1,
    CLASS_BIT_MAN   = 4'd2,
    CLASS_BIT_COUNT = 4'd3,
    CLASS_SHUFFLE   = 4'd4,
    CLASS_COMPARE   = 4'd5,
    CLASS_ABS_CLIP  = 4'd6,
    CLASS_MIN_MAX   = 4'd7,
    CLASS_DIV_REM   = 4'd8,
    CLASS_NONE      = 4'd15
  } op_class_t;

  typedef logic [11:0]                      csr_addr_t;
  typedef logic [NUM_CLASSES-1:0]           class_mask_t;
  // Bit index is class * NUM_LANES + lane
  typedef logic [NUM_LANES*NUM_CLASSES-1:0] fault_map_t;

  ////////////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////////////
  localparam csr_addr_t CSR_CNT_BASE     = 12'h7C0;
  localparam csr_addr_t CSR_FAULT_MAP_LO = CSR_CNT_BASE + 12'd36;
  localparam csr_addr_t CSR_FAULT_MAP_HI = CSR_CNT_BASE + 12'd37;

  localparam logic [CNT_W-1:0] DEF_ERR_THRESHOLD = 32'd8;
  localparam logic [CNT_W-1:0] DEF_ERR_INCREASE  = 32'd2;
  localparam logic [CNT_W-1:0] DEF_ERR_DECREASE  = 32'd1;

endpackage

//--- hw/op_class_decoder.sv
// Purely combinational; any code outside the kept operator subset yields CLASS_NONE
`timescale 1ns/1ps

module op_class_decoder import alu_health_pkg::*; (
  input  alu_op_t   op_i,
  output op_class_t class_o
);

  always_comb begin
    case (op_i)
      // Adder and shifter share the datapath
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA: begin
        class_o = CLASS_SHIFT_ADD;
      end

      ALU_XOR, ALU_OR, ALU_AND: begin
        class_o = CLASS_LOGIC;
      end

      // Single bit extract, clear and set
      ALU_BEXT, ALU_BCLR, ALU_BSET: begin
        class_o = CLASS_BIT_MAN;
      end

      ALU_FF1, ALU_CNT: begin
        class_o = CLASS_BIT_COUNT;
      end

      // Sign extension goes through the shuffle network
      ALU_EXT, ALU_SHUF: begin
        class_o = CLASS_SHUFFLE;
      end

      ALU_LTS, ALU_EQ: begin
        class_o = CLASS_COMPARE;
      end

      ALU_ABS, ALU_CLIP: begin
        class_o = CLASS_ABS_CLIP;
      end

      ALU_MIN, ALU_MAX: begin
        class_o = CLASS_MIN_MAX;
      end

      ALU_DIV, ALU_REM: begin
        class_o = CLASS_DIV_REM;
      end

      // Unknown opcode, event is dropped downstream
      default: begin
        class_o = CLASS_NONE;
      end
    endcase
  end

endmodule

//--- hw/error_counter_lane.sv
// One lane only; flags are sticky until reset and a CSR counter write beats a same-cycle event
`timescale 1ns/1ps

module error_counter_lane import alu_health_pkg::*; #(
  parameter logic [CNT_W-1:0] ERR_THRESHOLD = DEF_ERR_THRESHOLD,
  parameter logic [CNT_W-1:0] ERR_INCREASE  = DEF_ERR_INCREASE,
  parameter logic [CNT_W-1:0] ERR_DECREASE  = DEF_ERR_DECREASE
) (
  input  logic                                clock_gated,
  input  logic                                rst_n,
  // Event from the ALU lane
  input  logic                                ev_valid_i,
  input  op_class_t                           ev_class_i,
  input  logic                                ev_error_i,
  // CSR write strobes
  input  class_mask_t                         cnt_we_i,
  input  logic [CNT_W-1:0]                    cnt_wdata_i,
  input  class_mask_t                         flag_we_i,
  input  class_mask_t                         flag_wdata_i,
  // State out
  output logic [NUM_CLASSES-1:0][CNT_W-1:0]   counters_o,
  output class_mask_t                         faulty_o
);

  logic [CNT_W-1:0] cnt_q [NUM_CLASSES];
  class_mask_t      flag_q;
  class_mask_t      ev_hit;
  class_mask_t      thr_hit;

  ////////////////////////////////////////////////////////////////////
  // Count update rule
  ////////////////////////////////////////////////////////////////////

  // Error adds with saturation, clean op decays toward zero
  function automatic logic [CNT_W-1:0] next_count(
    input logic [CNT_W-1:0] cnt,
    input logic             err
  );
    logic [CNT_W:0]   sum;
    logic [CNT_W-1:0] res;
    sum = {1'b0, cnt} + {1'b0, ERR_INCREASE};
    if (err) begin
      res = sum[CNT_W] ? '1 : sum[CNT_W-1:0];
    end else if (cnt > ERR_DECREASE) begin
      res = cnt - ERR_DECREASE;
    end else begin
      res = '0;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Per class counters
  ////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_class

    // Faulty classes are frozen
    assign ev_hit[c] = ev_valid_i && (ev_class_i == op_class_t'(c)) && !flag_q[c];

    // Threshold check on the registered count, so flag lags by a cycle
    assign thr_hit[c] = (cnt_q[c] >= ERR_THRESHOLD);

    always_ff @(posedge clock_gated or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[c] <= '0;
      end else if (cnt_we_i[c]) begin
        cnt_q[c] <= cnt_wdata_i;
      end else if (ev_hit[c]) begin
        cnt_q[c] <= next_count(cnt_q[c], ev_error_i);
      end
    end

    assign counters_o[c] = cnt_q[c];
  end

  // Sticky fault flags, set only
  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      flag_q <= '0;
    end else begin
      flag_q <= flag_q | thr_hit | (flag_we_i & flag_wdata_i);
    end
  end

  assign faulty_o = flag_q;

endmodule

//--- hw/csr_ctrl.sv
// Requests are always accepted; reads answer one cycle later, writes take effect at the accepting edge
`timescale 1ns/1ps

module csr_ctrl import alu_health_pkg::*; (
  input  logic                                                clock_gated,
  input  logic                                                rst_n,
  // Host request
  input  logic                                                csr_req_valid_i,
  input  logic                                                csr_we_i,
  input  csr_addr_t                                           csr_addr_i,
  input  logic [CNT_W-1:0]                                    csr_wdata_i,
  // Lane state
  input  logic [NUM_LANES-1:0][NUM_CLASSES-1:0][CNT_W-1:0]    counters_i,
  input  fault_map_t                                          fault_map_i,
  // Lane write strobes
  output class_mask_t [NUM_LANES-1:0]                         cnt_we_o,
  output logic [CNT_W-1:0]                                    cnt_wdata_o,
  output class_mask_t [NUM_LANES-1:0]                         flag_we_o,
  output class_mask_t [NUM_LANES-1:0]                         flag_wdata_o,
  // Host response
  output logic                                                csr_rsp_valid_o,
  output logic [CNT_W-1:0]                                    csr_rdata_o
);

  localparam int unsigned LANE_W   = $clog2(NUM_LANES);
  localparam int unsigned MAP_HI_W = NUM_LANES*NUM_CLASSES - CNT_W;

  csr_addr_t           offset;
  logic [LANE_W-1:0]   lane_idx;
  logic [3:0]          class_idx;
  logic                is_cnt;
  logic                is_map_lo;
  logic                is_map_hi;
  logic                wr_acc;
  logic                rd_acc;
  fault_map_t          map_we;
  fault_map_t          map_wdata;
  logic [CNT_W-1:0]    rd_data;
  logic                rsp_valid_q;
  logic [CNT_W-1:0]    rdata_q;

  ////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////

  // Wraps for addresses below the base, so the range check alone is enough
  assign offset    = csr_addr_i - CSR_CNT_BASE;
  assign is_cnt    = (offset < csr_addr_t'(NUM_LANES*NUM_CLASSES));
  assign lane_idx  = offset[LANE_W-1:0];
  assign class_idx = offset[LANE_W +: 4];
  assign is_map_lo = (csr_addr_i == CSR_FAULT_MAP_LO);
  assign is_map_hi = (csr_addr_i == CSR_FAULT_MAP_HI);

  assign wr_acc = csr_req_valid_i && csr_we_i;
  assign rd_acc = csr_req_valid_i && !csr_we_i;

  ////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    cnt_we_o = '0;
    if (wr_acc && is_cnt) begin
      cnt_we_o[lane_idx][class_idx] = 1'b1;
    end
  end

  assign cnt_wdata_o = csr_wdata_i;

  // Both map words laid over the full map, the enable picks the half
  assign map_wdata = {csr_wdata_i[MAP_HI_W-1:0], csr_wdata_i};
  assign map_we    = {{MAP_HI_W{wr_acc && is_map_hi}}, {CNT_W{wr_acc && is_map_lo}}};

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_class
      assign flag_we_o[l][c]    = map_we[c*NUM_LANES + l];
      assign flag_wdata_o[l][c] = map_wdata[c*NUM_LANES + l];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    if (is_cnt) begin
      rd_data = counters_i[lane_idx][class_idx];
    end else if (is_map_lo) begin
      rd_data = fault_map_i[CNT_W-1:0];
    end else if (is_map_hi) begin
      rd_data = {{(CNT_W-MAP_HI_W){1'b0}}, fault_map_i[CNT_W +: MAP_HI_W]};
    end
  end

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rdata_q     <= '0;
    end else begin
      rsp_valid_q <= rd_acc;
      if (rd_acc) begin
        rdata_q <= rd_data;
      end
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rdata_o     = rdata_q;

endmodule

//--- hw/alu_health_monitor.sv
// Single clock domain; events have no back-pressure and at most one event per lane per cycle
`timescale 1ns/1ps

module alu_health_monitor import alu_health_pkg::*; #(
  parameter logic [CNT_W-1:0] ERR_THRESHOLD = DEF_ERR_THRESHOLD,
  parameter logic [CNT_W-1:0] ERR_INCREASE  = DEF_ERR_INCREASE,
  parameter logic [CNT_W-1:0] ERR_DECREASE  = DEF_ERR_DECREASE
) (
  input  logic                        clock_gated,
  input  logic                        rst_n,
  // ALU lane events
  input  logic [NUM_LANES-1:0]        ev_valid_i,
  input  alu_op_t [NUM_LANES-1:0]     ev_op_i,
  input  logic [NUM_LANES-1:0]        ev_error_i,
  // CSR port
  input  logic                        csr_req_valid_i,
  input  logic                        csr_we_i,
  input  csr_addr_t                   csr_addr_i,
  input  logic [CNT_W-1:0]            csr_wdata_i,
  output logic                        csr_rsp_valid_o,
  output logic [CNT_W-1:0]            csr_rdata_o,
  // Sticky fault flags
  output fault_map_t                  fault_map_o
);

  op_class_t                                          lane_class [NUM_LANES];
  logic [NUM_LANES-1:0][NUM_CLASSES-1:0][CNT_W-1:0]   lane_counters;
  class_mask_t [NUM_LANES-1:0]                        lane_faulty;
  class_mask_t [NUM_LANES-1:0]                        cnt_we;
  logic [CNT_W-1:0]                                   cnt_wdata;
  class_mask_t [NUM_LANES-1:0]                        flag_we;
  class_mask_t [NUM_LANES-1:0]                        flag_wdata;

  ////////////////////////////////////////////////////////////////////
  // Per lane decode and counting
  ////////////////////////////////////////////////////////////////////
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane

    op_class_decoder u_decoder (
      .op_i    (ev_op_i[l]),
      .class_o (lane_class[l])
    );

    error_counter_lane #(
      .ERR_THRESHOLD (ERR_THRESHOLD),
      .ERR_INCREASE  (ERR_INCREASE),
      .ERR_DECREASE  (ERR_DECREASE)
    ) u_lane (
      .clock_gated  (clock_gated),
      .rst_n        (rst_n),
      .ev_valid_i   (ev_valid_i[l]),
      .ev_class_i   (lane_class[l]),
      .ev_error_i   (ev_error_i[l]),
      .cnt_we_i     (cnt_we[l]),
      .cnt_wdata_i  (cnt_wdata),
      .flag_we_i    (flag_we[l]),
      .flag_wdata_i (flag_wdata[l]),
      .counters_o   (lane_counters[l]),
      .faulty_o     (lane_faulty[l])
    );

    // Map is class-major, lane in the low bits
    for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_map
      assign fault_map_o[c*NUM_LANES + l] = lane_faulty[l][c];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // CSR access
  ////////////////////////////////////////////////////////////////////
  csr_ctrl u_csr_ctrl (
    .clock_gated     (clock_gated),
    .rst_n           (rst_n),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_we_i        (csr_we_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .counters_i      (lane_counters),
    .fault_map_i     (fault_map_o),
    .cnt_we_o        (cnt_we),
    .cnt_wdata_o     (cnt_wdata),
    .flag_we_o       (flag_we),
    .flag_wdata_o    (flag_wdata),
    .csr_rsp_valid_o (csr_rsp_valid_o),
    .csr_rdata_o     (csr_rdata_o)
  );

endmodule

//--- verification/tb_ref_model.svh
// Included inside the testbench module after MAP_W is declared; mirrors the default parameters only
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Mirror of every counter and the sticky fault map
logic [CNT_W-1:0] ref_cnt [NUM_LANES][NUM_CLASSES];
fault_map_t       ref_flag;
int               errors;

//////////////////////////////////////////////////////////////////////
// Expected behaviour
//////////////////////////////////////////////////////////////////////

// Count after one event on a class that may already be faulty
function automatic logic [CNT_W-1:0] ref_next_count(
  input logic [CNT_W-1:0] cnt,
  input logic             flag,
  input logic             err,
  input logic [CNT_W-1:0] inc,
  input logic [CNT_W-1:0] dec
);
  if (flag) begin
    return cnt;
  end
  if (err) begin
    return (cnt > {CNT_W{1'b1}} - inc) ? {CNT_W{1'b1}} : cnt + inc;
  end
  return (cnt > dec) ? cnt - dec : '0;
endfunction

// Operator grouping
function automatic op_class_t ref_class(input alu_op_t op);
  case (op)
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA: return CLASS_SHIFT_ADD;
    ALU_XOR, ALU_OR, ALU_AND:                   return CLASS_LOGIC;
    ALU_BEXT, ALU_BCLR, ALU_BSET:               return CLASS_BIT_MAN;
    ALU_FF1, ALU_CNT:                           return CLASS_BIT_COUNT;
    ALU_EXT, ALU_SHUF:                          return CLASS_SHUFFLE;
    ALU_LTS, ALU_EQ:                            return CLASS_COMPARE;
    ALU_ABS, ALU_CLIP:                          return CLASS_ABS_CLIP;
    ALU_MIN, ALU_MAX:                           return CLASS_MIN_MAX;
    ALU_DIV, ALU_REM:                           return CLASS_DIV_REM;
    default:                                    return CLASS_NONE;
  endcase
endfunction

// Register view of the mirror as the host sees it
function automatic logic [CNT_W-1:0] ref_read(input csr_addr_t addr);
  int off;
  off = int'(addr) - int'(CSR_CNT_BASE);
  if (off >= 0 && off < MAP_W) begin
    return ref_cnt[off % NUM_LANES][off / NUM_LANES];
  end else if (addr == CSR_FAULT_MAP_LO) begin
    return ref_flag[CNT_W-1:0];
  end else if (addr == CSR_FAULT_MAP_HI) begin
    return CNT_W'(ref_flag[MAP_W-1:CNT_W]);
  end
  return '0;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////
task automatic check_count(
  input string            name,
  input logic [CNT_W-1:0] exp,
  input logic [CNT_W-1:0] act
);
  if (act !== exp) begin
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    errors++;
  end
endtask

task automatic check_fault_map(input string name, input fault_map_t exp, input fault_map_t act);
  if (act !== exp) begin
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    errors++;
  end
endtask

task automatic check_valid(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    errors++;
  end
endtask

`endif

//--- verification/tb_alu_health_monitor.sv
// Runs the DUT with default parameters only; each clock edge is modelled once by the stimulus process
`timescale 1ns/1ps

module tb_alu_health_monitor import alu_health_pkg::*; ();

  localparam int          CLK_PERIOD     = 40;
  localparam int          RST_CYCLES     = 2;
  localparam int          RAND_CYCLES    = 60;
  localparam int          MAP_W          = NUM_LANES * NUM_CLASSES;
  localparam int          NUM_REGS       = MAP_W + 2;
  // Two full sweeps, the random phase and about sixty directed cycles
  localparam int          TEST_CYCLES    = RST_CYCLES + 2 * (NUM_REGS + 2) + RAND_CYCLES + 60;
  localparam int          TIMEOUT_MARGIN = 50 * CLK_PERIOD;
  localparam logic [31:0] SEED           = 32'hffa32c77;

  typedef alu_op_t [NUM_LANES-1:0] lane_ops_t;

  logic                 clock_gated = 1'b0;
  logic                 rst_n;
  logic [NUM_LANES-1:0] ev_valid_i;
  lane_ops_t            ev_op_i;
  logic [NUM_LANES-1:0] ev_error_i;
  logic                 csr_req_valid_i;
  logic                 csr_we_i;
  csr_addr_t            csr_addr_i;
  logic [CNT_W-1:0]     csr_wdata_i;
  logic                 csr_rsp_valid_o;
  logic [CNT_W-1:0]     csr_rdata_o;
  fault_map_t           fault_map_o;

  // Inputs the DUT takes at the next edge
  logic [NUM_LANES-1:0] pend_valid;
  lane_ops_t            pend_op;
  logic [NUM_LANES-1:0] pend_err;
  logic                 pend_req;
  logic                 pend_we;
  csr_addr_t            pend_addr;
  logic [CNT_W-1:0]     pend_wdata;

  logic [CNT_W-1:0]     exp_q [$];
  string                name_q [$];
  logic                 exp_rsp = 1'b0;
  logic                 check_en = 1'b0;
  int                   test_no;
  int                   tests_failed;
  int                   err_mark;
  alu_op_t              op_list [23] = '{
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND,
    ALU_BEXT, ALU_BCLR, ALU_BSET, ALU_FF1, ALU_CNT, ALU_EXT, ALU_SHUF, ALU_LTS,
    ALU_EQ, ALU_ABS, ALU_CLIP, ALU_MIN, ALU_MAX, ALU_DIV, ALU_REM
  };

  `include "tb_ref_model.svh"

  alu_health_monitor u_dut (
    .clock_gated     (clock_gated),
    .rst_n           (rst_n),
    .ev_valid_i      (ev_valid_i),
    .ev_op_i         (ev_op_i),
    .ev_error_i      (ev_error_i),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_we_i        (csr_we_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_rsp_valid_o (csr_rsp_valid_o),
    .csr_rdata_o     (csr_rdata_o),
    .fault_map_o     (fault_map_o)
  );

  always #(CLK_PERIOD / 2) clock_gated = ~clock_gated;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic lane_ops_t same_op(input alu_op_t op);
    lane_ops_t ops;
    for (int l = 0; l < NUM_LANES; l++) begin
      ops[l] = op;
    end
    return ops;
  endfunction

  // Mirror update for one edge; read data is taken before the edge
  task automatic model_edge();
    fault_map_t flag_set;
    int         ci;
    int         off;
    flag_set = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        flag_set[c*NUM_LANES + l] = (ref_cnt[l][c] >= DEF_ERR_THRESHOLD);
      end
    end
    exp_rsp = pend_req && !pend_we;
    if (pend_req && !pend_we) begin
      exp_q.push_back(ref_read(pend_addr));
      name_q.push_back($sformatf("csr_rdata_o[%h]", pend_addr));
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      ci = int'(ref_class(pend_op[l]));
      if (pend_valid[l] && ci < NUM_CLASSES) begin
        ref_cnt[l][ci] = ref_next_count(ref_cnt[l][ci], ref_flag[ci*NUM_LANES + l],
                                        pend_err[l], DEF_ERR_INCREASE, DEF_ERR_DECREASE);
      end
    end
    if (pend_req && pend_we) begin
      off = int'(pend_addr) - int'(CSR_CNT_BASE);
      // Host write beats an event on the same counter
      if (off >= 0 && off < MAP_W) begin
        ref_cnt[off % NUM_LANES][off / NUM_LANES] = pend_wdata;
      end else if (pend_addr == CSR_FAULT_MAP_LO) begin
        flag_set[CNT_W-1:0] |= pend_wdata;
      end else if (pend_addr == CSR_FAULT_MAP_HI) begin
        flag_set[MAP_W-1:CNT_W] |= pend_wdata[MAP_W-CNT_W-1:0];
      end
    end
    ref_flag = ref_flag | flag_set;
  endtask

  task automatic drive(
    input logic [NUM_LANES-1:0] v,
    input lane_ops_t            op,
    input logic [NUM_LANES-1:0] err,
    input logic                 req,
    input logic                 we,
    input csr_addr_t            addr,
    input logic [CNT_W-1:0]     wdata
  );
    @(posedge clock_gated);
    model_edge();
    ev_valid_i      <= v;
    ev_op_i         <= op;
    ev_error_i      <= err;
    csr_req_valid_i <= req;
    csr_we_i        <= we;
    csr_addr_i      <= addr;
    csr_wdata_i     <= wdata;
    pend_valid = v;
    pend_op    = op;
    pend_err   = err;
    pend_req   = req;
    pend_we    = we;
    pend_addr  = addr;
    pend_wdata = wdata;
  endtask

  task automatic idle();
    drive('0, same_op(ALU_ADD), '0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic csr_read(input csr_addr_t addr);
    drive('0, same_op(ALU_ADD), '0, 1'b1, 1'b0, addr, '0);
  endtask

  task automatic csr_write(input csr_addr_t addr, input logic [CNT_W-1:0] data);
    drive('0, same_op(ALU_ADD), '0, 1'b1, 1'b1, addr, data);
  endtask

  task automatic lane_event(input int lane, input alu_op_t op, input logic err);
    logic [NUM_LANES-1:0] v;
    v = '0;
    v[lane] = 1'b1;
    drive(v, same_op(op), {NUM_LANES{err}}, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic read_all();
    for (int a = 0; a < NUM_REGS; a++) begin
      csr_read(CSR_CNT_BASE + csr_addr_t'(a));
    end
  endtask

  // Two idle edges let the last read response reach the comparer
  task automatic finish_test(input string name);
    idle();
    idle();
    test_no++;
    if (errors == err_mark) begin
      $display("Test %0d, %s: ok", test_no, name);
    end else begin
      $display("Test %0d, %s: %0d errors", test_no, name, errors - err_mark);
      tests_failed++;
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparer sampling at the falling edge
  //////////////////////////////////////////////////////////////////////
  always @(negedge clock_gated) begin
    if (check_en) begin
      check_fault_map("fault_map_o", ref_flag, fault_map_o);
      check_valid("csr_rsp_valid_o", exp_rsp, csr_rsp_valid_o);
      if (csr_rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Read response at %0t ns without an outstanding read", $time);
          errors++;
        end else begin
          check_count(name_q.pop_front(), exp_q.pop_front(), csr_rdata_o);
        end
      end
    end
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD + TIMEOUT_MARGIN);
    $display("Timeout: the tests did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  initial begin
    lane_ops_t            rop;
    logic [NUM_LANES-1:0] rv;
    logic [NUM_LANES-1:0] rerr;
    logic [31:0]          rnd;
    int                   ridx;
    int                   n;
    rnd = $urandom(SEED);
    rst_n           <= 1'b0;
    ev_valid_i      <= '0;
    ev_op_i         <= same_op(ALU_ADD);
    ev_error_i      <= '0;
    csr_req_valid_i <= 1'b0;
    csr_we_i        <= 1'b0;
    csr_addr_i      <= '0;
    csr_wdata_i     <= '0;
    pend_valid = '0;
    pend_op    = same_op(ALU_ADD);
    pend_err   = '0;
    pend_req   = 1'b0;
    pend_we    = 1'b0;
    pend_addr  = '0;
    pend_wdata = '0;
    ref_flag   = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        ref_cnt[l][c] = '0;
      end
    end
    repeat (RST_CYCLES) @(posedge clock_gated);
    rst_n <= 1'b1;
    check_en = 1'b1;

    read_all();
    finish_test("reset values");

    // About one event in four carries an error, so counts often sit at the floor
    repeat (RAND_CYCLES) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        rnd = $urandom;
        ridx = $urandom % 24;
        rv[l] = rnd[2];
        rerr[l] = (rnd[1:0] == 2'b00);
        // Index 23 gives an operator outside the kept subset
        rop[l] = (ridx < 23) ? op_list[ridx] : alu_op_t'(7'h7e);
      end
      drive(rv, rop, rerr, 1'b0, 1'b0, '0, '0);
    end
    read_all();
    finish_test("random events");

    // DUT flag is polled at the falling edge where it is stable
    n = 0;
    @(negedge clock_gated);
    while (!fault_map_o[int'(CLASS_ABS_CLIP)*NUM_LANES + 2] && n < 12) begin
      lane_event(2, ALU_CLIP, 1'b1);
      n++;
      @(negedge clock_gated);
    end
    if (!fault_map_o[int'(CLASS_ABS_CLIP)*NUM_LANES + 2]) begin
      $display("Fault flag of lane 2 abs/clip was never raised by repeated errors");
      errors++;
    end
    lane_event(2, ALU_ABS, 1'b0);
    lane_event(2, ALU_ABS, 1'b0);
    lane_event(2, ALU_CLIP, 1'b1);
    csr_read(CSR_CNT_BASE + csr_addr_t'(int'(CLASS_ABS_CLIP) * NUM_LANES + 2));
    finish_test("threshold and hold");

    // Random loads go to lane 3 only and leave lanes 0 to 2 mostly unflagged
    repeat (6) begin
      rnd = $urandom;
      csr_write(CSR_CNT_BASE + csr_addr_t'((rnd[7:4] % NUM_CLASSES) * NUM_LANES + 3), $urandom);
      csr_read(CSR_CNT_BASE + csr_addr_t'((rnd[7:4] % NUM_CLASSES) * NUM_LANES + 3));
    end
    // Error event on lane 1 min/max at the same edge as a write to that counter
    drive(4'b0010, same_op(ALU_MIN), 4'b0010, 1'b1, 1'b1,
          CSR_CNT_BASE + csr_addr_t'(int'(CLASS_MIN_MAX) * NUM_LANES + 1), 32'd5);
    csr_read(CSR_CNT_BASE + csr_addr_t'(int'(CLASS_MIN_MAX) * NUM_LANES + 1));
    csr_write(CSR_CNT_BASE + csr_addr_t'(int'(CLASS_BIT_COUNT) * NUM_LANES), DEF_ERR_THRESHOLD);
    idle();
    csr_read(CSR_CNT_BASE + csr_addr_t'(int'(CLASS_BIT_COUNT) * NUM_LANES));
    finish_test("counter writes");

    csr_write(CSR_FAULT_MAP_LO, $urandom);
    csr_write(CSR_FAULT_MAP_HI, 32'hffff_fff5);
    csr_write(CSR_FAULT_MAP_LO, '0);
    csr_write(CSR_FAULT_MAP_HI, '0);
    csr_read(CSR_FAULT_MAP_LO);
    csr_read(CSR_FAULT_MAP_HI);
    csr_read(CSR_FAULT_MAP_HI + 12'd1);
    csr_read(12'h000);
    csr_read(12'h7bf);
    csr_read(12'hfff);
    finish_test("fault map writes");

    if (exp_q.size() != 0) begin
      $display("%0d read responses never arrived", exp_q.size());
      errors++;
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_no, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verification
hw/alu_health_pkg.sv
hw/op_class_decoder.sv
hw/error_counter_lane.sv
hw/csr_ctrl.sv
hw/alu_health_monitor.sv
verification/tb_alu_health_monitor.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := vlog.f
TOP        := tb_alu_health_monitor
RTL_TOP    := alu_health_monitor
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --Mdir $(BUILD_DIR)
PASS_MSG   := TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/tb_ref_model.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
